// ==== hw/eth_addr_classify.sv ====
// destination address classifier for unicast, multicast and broadcast frames
`timescale 1ns/1ps

module eth_addr_classify (
    input  logic       clk,
    input  logic       reset_crc,
    input  logic [7:0] hdr_byte,
    input  logic       hdr_restart,
    input  logic       hdr_advance,
    output logic       is_mcast,
    output logic       is_bcast
);
    import eth_rx_pkg::*;

    logic [hdr_w-1:0] hdr_ptr;

    always_ff @(posedge clk) begin
        if (reset_crc || hdr_restart) begin
            hdr_ptr  <= '0;
            is_mcast <= 1'b0;
            is_bcast <= 1'b0;
        end else if (hdr_advance) begin
            if (!(&hdr_ptr)) begin
                hdr_ptr <= hdr_ptr + 1'b1;
            end
            if (hdr_ptr == '0) begin
                // group bit is the first bit on the wire
                is_mcast <= hdr_byte[0];
                is_bcast <= (hdr_byte == 8'hff);
            end else if (hdr_ptr <= hdr_w'(5)) begin
                // rest of the destination address
                is_bcast <= is_bcast && (hdr_byte == 8'hff);
            end
        end
    end

endmodule

// ==== hw/eth_crc32.sv ====
// running ethernet CRC-32 over received bytes with residue check
`timescale 1ns/1ps

module eth_crc32 (
    input  logic       clk,
    input  logic       reset_crc,
    input  logic [7:0] data,
    input  logic       crc_restart,
    input  logic       crc_update,
    output logic       crc_ok
);
    import eth_rx_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_next;
    logic [31:0] poly_rev;

    // reflected polynomial, data enters LSB first
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            poly_rev[i] = crc_poly[31-i];
        end
    end

    // one byte, one bit per step
    always_comb begin
        crc_next = crc_q;
        for (int b = 0; b < 8; b++) begin
            if (crc_next[0] ^ data[b]) begin
                crc_next = (crc_next >> 1) ^ poly_rev;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_restart) begin
            crc_q <= '1;
        end else if (crc_update) begin
            crc_q <= crc_next;
        end
    end

    // register plus current byte, FCS included, lands on the residue
    assign crc_ok = (crc_next == crc_residue);

endmodule

// ==== hw/eth_rx_framer.sv ====
// receive framing FSM with length tracking, output stream and end-of-frame stats
`timescale 1ns/1ps

module eth_rx_framer (
    input  logic                         clk,
    input  logic                         reset_crc,
    input  eth_rx_pkg::gmii_beat_t       gmii_now,
    input  eth_rx_pkg::gmii_beat_t       stage0,
    input  eth_rx_pkg::gmii_beat_t       stage4,
    input  logic                         crc_ok,
    input  logic                         is_mcast,
    input  logic                         is_bcast,
    input  logic [eth_rx_pkg::len_w-1:0] cfg_max_len,
    input  logic                         cfg_enable,
    output logic                         crc_restart,
    output logic                         crc_update,
    output logic                         hdr_restart,
    output logic                         hdr_advance,
    output eth_rx_pkg::rx_stream_t       rx_out,
    output eth_rx_pkg::rx_stat_t         rx_stat
);
    import eth_rx_pkg::*;

    framer_state_t    state_q, state_d;
    logic             in_pre_q, in_pre_d;
    logic             frame_err_q, frame_err_d;
    logic [len_w-1:0] frame_len_q, frame_len_d;
    logic [len_w-1:0] len_lim_q, len_lim_d;
    logic             frame_end;
    logic             fail;
    rx_stream_t       out_d;
    rx_stat_t         stat_d;

    assign hdr_restart = (state_q != payload);
    assign hdr_advance = (state_q == payload);
    assign frame_end   = (state_q == payload) && !gmii_now.dv;
    assign fail        = frame_err_q || !crc_ok || (len_lim_q == '0);

    always_comb begin
        state_d     = state_q;
        in_pre_d    = in_pre_q;
        frame_err_d = frame_err_q;
        frame_len_d = frame_len_q;
        len_lim_d   = len_lim_q;
        crc_restart = 1'b0;
        crc_update  = 1'b0;
        out_d       = '0;
        stat_d      = '0;

        // saturating length and remaining-length counters
        if (!(&frame_len_q)) begin
            frame_len_d = frame_len_q + 1'b1;
        end
        if (len_lim_q != '0) begin
            len_lim_d = len_lim_q - 1'b1;
        end

        case (state_q)
            idle: begin
                crc_restart = 1'b1;
                frame_err_d = 1'b0;
                frame_len_d = len_w'(1);
                len_lim_d   = cfg_max_len;
                if (!stage0.dv) begin
                    in_pre_d = 1'b0;
                end else if (stage0.er) begin
                    in_pre_d = 1'b0;
                    stat_d.err_framing = 1'b1;
                end else if (stage0.data == eth_pre) begin
                    in_pre_d = 1'b1;
                end else if (stage0.data == eth_sfd) begin
                    in_pre_d = 1'b0;
                    if (in_pre_q && cfg_enable) begin
                        stat_d.rx_byte = 1'b1;
                        // first byte after the SFD is already on the live input
                        frame_err_d = gmii_now.dv && gmii_now.er;
                        state_d = pipe;
                    end
                end else begin
                    in_pre_d = 1'b0;
                end
            end
            pipe: begin
                // wait for the SFD to reach the end of the delay line
                crc_update = 1'b1;
                stat_d.rx_byte = stage0.dv;
                if (gmii_now.dv && gmii_now.er) begin
                    frame_err_d = 1'b1;
                end
                if (stage4.dv && !stage4.er && stage4.data == eth_sfd) begin
                    state_d = payload;
                end
            end
            payload: begin
                out_d.data  = stage4.data;
                out_d.valid = 1'b1;
                stat_d.rx_byte = stage0.dv;
                if (gmii_now.dv && gmii_now.er) begin
                    frame_err_d = 1'b1;
                end
                if (frame_end) begin
                    crc_restart = 1'b1;
                    out_d.last  = 1'b1;
                    out_d.user  = fail;
                    stat_d.pkt_len      = frame_len_q;
                    stat_d.ucast        = !is_mcast;
                    stat_d.mcast        = is_mcast && !is_bcast;
                    stat_d.bcast        = is_bcast;
                    stat_d.good         = !fail;
                    stat_d.bad          = fail;
                    stat_d.err_oversize = (len_lim_q == '0);
                    stat_d.err_bad_fcs  = !frame_err_q && !crc_ok;
                    stat_d.err_framing  = frame_err_q;
                    state_d = idle;
                end else begin
                    crc_update = 1'b1;
                end
            end
            default: state_d = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        state_q     <= state_d;
        in_pre_q    <= in_pre_d;
        frame_err_q <= frame_err_d;
        frame_len_q <= frame_len_d;
        len_lim_q   <= len_lim_d;
        rx_out      <= out_d;
        rx_stat     <= stat_d;
        if (reset_crc) begin
            state_q      <= idle;
            in_pre_q     <= 1'b0;
            frame_err_q  <= 1'b0;
            rx_out.valid <= 1'b0;
            rx_out.last  <= 1'b0;
            rx_out.user  <= 1'b0;
            rx_stat      <= '0;
        end
    end

    idle_no_beat: assert property (
        @(posedge clk) disable iff (reset_crc)
        state_q == idle |=> !rx_out.valid
    );

    last_is_beat: assert property (
        @(posedge clk) disable iff (reset_crc)
        rx_out.last |-> rx_out.valid && (rx_stat.good || rx_stat.bad)
    );

    good_xor_bad: assert property (
        @(posedge clk) disable iff (reset_crc)
        !(rx_stat.good && rx_stat.bad)
    );

endmodule

// ==== hw/eth_rx_pkg.sv ====
// ethernet receive framer shared constants, FSM state and stream records
package eth_rx_pkg;

    // framing bytes
    localparam logic [7:0] eth_pre = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hd5;

    // CRC-32, normal form; the datapath walks it LSB first
    localparam logic [31:0] crc_poly    = 32'h04c11db7;
    localparam logic [31:0] crc_residue = ~32'h2144df1c;

    localparam int delay_depth = 5;
    localparam int len_w       = 16;
    localparam int hdr_w       = 4;

    localparam logic [len_w-1:0] default_max_len = 16'd1518;

    typedef struct packed {
        logic [7:0] data;
        logic       dv;
        logic       er;
    } gmii_beat_t;

    // user marks a bad frame, valid on the last beat only
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       last;
        logic       user;
    } rx_stream_t;

    typedef struct packed {
        logic [len_w-1:0] pkt_len;
        logic             rx_byte;
        logic             ucast;
        logic             mcast;
        logic             bcast;
        logic             good;
        logic             bad;
        logic             err_oversize;
        logic             err_bad_fcs;
        logic             err_framing;
    } rx_stat_t;

    typedef enum logic [1:0] {
        idle,
        pipe,
        payload
    } framer_state_t;

endpackage

// ==== hw/gmii_rx_delay.sv ====
// GMII delay line, holds back the last four bytes so the FCS never reaches the output
`timescale 1ns/1ps

module gmii_rx_delay (
    input  logic                   clk,
    input  logic                   reset_crc,
    input  eth_rx_pkg::gmii_beat_t gmii_in,
    output eth_rx_pkg::gmii_beat_t stage0,
    output eth_rx_pkg::gmii_beat_t stage4
);
    import eth_rx_pkg::*;

    gmii_beat_t beat_q [delay_depth];

    always_ff @(posedge clk) begin
        beat_q[0] <= gmii_in;
        for (int i = 1; i < delay_depth; i++) begin
            beat_q[i] <= beat_q[i-1];
        end
        if (reset_crc) begin
            for (int i = 0; i < delay_depth; i++) begin
                beat_q[i].dv <= 1'b0;
            end
        end
    end

    assign stage0 = beat_q[0];
    assign stage4 = beat_q[delay_depth-1];

    // receive error is only expected inside a data burst
    er_needs_dv: assert property (
        @(posedge clk) disable iff (reset_crc)
        stage0.er |-> stage0.dv
    );

endmodule

// ==== hw/gmii_rx_top.sv ====
// gigabit ethernet receive framer top, GMII bytes in and checked frame stream out
`timescale 1ns/1ps

// cfg_max_len is normally eth_rx_pkg::default_max_len (1518)
module gmii_rx_top (
    input  logic                         clk,
    input  logic                         reset_crc,
    input  eth_rx_pkg::gmii_beat_t       gmii_in,
    input  logic [eth_rx_pkg::len_w-1:0] cfg_max_len,
    input  logic                         cfg_enable,
    output eth_rx_pkg::rx_stream_t       rx_out,
    output eth_rx_pkg::rx_stat_t         rx_stat
);
    import eth_rx_pkg::*;

    gmii_beat_t stage0;
    gmii_beat_t stage4;
    logic       crc_restart;
    logic       crc_update;
    logic       crc_ok;
    logic       hdr_restart;
    logic       hdr_advance;
    logic       is_mcast;
    logic       is_bcast;

    gmii_rx_delay u_delay (
        .clk       (clk),
        .reset_crc (reset_crc),
        .gmii_in   (gmii_in),
        .stage0    (stage0),
        .stage4    (stage4)
    );

    eth_crc32 u_crc (
        .clk         (clk),
        .reset_crc   (reset_crc),
        .data        (stage0.data),
        .crc_restart (crc_restart),
        .crc_update  (crc_update),
        .crc_ok      (crc_ok)
    );

    eth_addr_classify u_classify (
        .clk         (clk),
        .reset_crc   (reset_crc),
        .hdr_byte    (stage4.data),
        .hdr_restart (hdr_restart),
        .hdr_advance (hdr_advance),
        .is_mcast    (is_mcast),
        .is_bcast    (is_bcast)
    );

    eth_rx_framer u_framer (
        .clk         (clk),
        .reset_crc   (reset_crc),
        .gmii_now    (gmii_in),
        .stage0      (stage0),
        .stage4      (stage4),
        .crc_ok      (crc_ok),
        .is_mcast    (is_mcast),
        .is_bcast    (is_bcast),
        .cfg_max_len (cfg_max_len),
        .cfg_enable  (cfg_enable),
        .crc_restart (crc_restart),
        .crc_update  (crc_update),
        .hdr_restart (hdr_restart),
        .hdr_advance (hdr_advance),
        .rx_out      (rx_out),
        .rx_stat     (rx_stat)
    );

endmodule

// ==== list.f ====
hw/eth_rx_pkg.sv
hw/gmii_rx_delay.sv
hw/eth_crc32.sv
hw/eth_addr_classify.sv
hw/eth_rx_framer.sv
hw/gmii_rx_top.sv
tb/rx_checker.sv
tb/tb_gmii_rx.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_gmii_rx -f list.f -o tb_gmii_rx \
    && ./obj_dir/tb_gmii_rx > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

// ==== tb/rx_checker.sv ====
// output monitor that compares the framer's stream beats and frame-end stats
`timescale 1ns/1ps

module rx_checker (
    input logic                   clk,
    input logic                   reset_crc,
    input eth_rx_pkg::rx_stream_t rx_out,
    input eth_rx_pkg::rx_stat_t   rx_stat
);
    import eth_rx_pkg::*;

    localparam int frame_timeout = 64;

    logic [7:0] exp_bytes [$];
    string      test_name = "none";
    rx_stat_t   exp_stat;
    logic       exp_user;
    logic       frame_open = 1'b0;
    int         beat_base = 0;
    int         last_base = 0;
    int         byte_base = 0;
    int         exp_byte_cnt = 0;
    int         beats_seen = 0;
    int         lasts_seen = 0;
    int         bytes_seen = 0;
    int         beat_idx;
    int         data_errs = 0;
    int         stat_errs = 0;
    int         proto_errs = 0;
    int         timeout_errs = 0;

    task automatic start_frame(input string name, input logic beats_due, input int byte_cnt,
                               input rx_stat_t stat, input logic user);
        test_name = name;
        exp_stat  = stat;
        exp_user  = user;
        exp_bytes.delete();
        beat_base    = beats_seen;
        last_base    = lasts_seen;
        byte_base    = bytes_seen;
        exp_byte_cnt = byte_cnt;
        frame_open   = beats_due;
    endtask

    task automatic push_byte(input logic [7:0] b);
        exp_bytes.push_back(b);
    endtask

    task automatic wait_frame();
        int n;
        n = 0;
        while (frame_open && lasts_seen == last_base && n < frame_timeout) begin
            @(negedge clk);
            n++;
        end
        if (frame_open && lasts_seen == last_base) begin
            $display("%s: no last beat arrived within %0d cycles", test_name, frame_timeout);
            timeout_errs++;
        end
        if (bytes_seen - byte_base != exp_byte_cnt) begin
            $display("ERROR %s: byte pulses expected %0d actual %0d",
                     test_name, exp_byte_cnt, bytes_seen - byte_base);
            stat_errs++;
        end
        frame_open = 1'b0;
    endtask

    // sample mid-cycle where the registered outputs are stable
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (rx_stat.rx_byte) begin
                bytes_seen++;
            end
            if (rx_out.valid) begin
                beat_idx = beats_seen - beat_base;
                beats_seen++;
                if (!frame_open || beat_idx >= exp_bytes.size()) begin
                    $display("%s: output beat arrived when no byte was expected", test_name);
                    proto_errs++;
                end else if (rx_out.data !== exp_bytes[beat_idx]) begin
                    $display("ERROR %s: byte %0d expected %02h actual %02h",
                             test_name, beat_idx, exp_bytes[beat_idx], rx_out.data);
                    data_errs++;
                end
                if (rx_out.last) begin
                    lasts_seen++;
                    if (frame_open && beat_idx + 1 != exp_bytes.size()) begin
                        $display("%s: frame ended after %0d bytes instead of %0d",
                                 test_name, beat_idx + 1, exp_bytes.size());
                        proto_errs++;
                    end
                    if (frame_open && rx_out.user !== exp_user) begin
                        $display("ERROR %s: user on last expected %0b actual %0b",
                                 test_name, exp_user, rx_out.user);
                        stat_errs++;
                    end
                    if (frame_open && rx_stat !== exp_stat) begin
                        $display("ERROR %s: stats expected %06h actual %06h",
                                 test_name, exp_stat, rx_stat);
                        stat_errs++;
                    end
                end
            end else if (rx_stat.good || rx_stat.bad) begin
                $display("%s: frame-end stats pulsed without a last beat", test_name);
                proto_errs++;
            end
        end
    end

endmodule

// ==== tb/tb_gmii_rx.sv ====
// testbench that sends a table of frames to the GMII receive framer and checks the results
`timescale 1ns/1ps

module tb_gmii_rx;
    import eth_rx_pkg::*;

    localparam int          n_tests     = 8;
    localparam int          drive_delay = 2;
    localparam int          gap_cycles  = 12;
    localparam logic [15:0] no_err      = 16'hffff;
    localparam logic [47:0] ucast_mac   = 48'h001a2b3c4d5e;
    localparam logic [47:0] mcast_mac   = 48'h01005e0000fb;
    localparam logic [47:0] src_mac     = 48'h00112233445a;

    typedef enum logic [1:0] {dest_ucast, dest_mcast, dest_bcast} dest_kind_t;

    // exp_flags holds good, oversize, bad FCS and framing
    typedef struct packed {
        dest_kind_t  dest;
        logic [15:0] pay_len;
        logic        bad_fcs;
        logic [15:0] err_at;
        logic [15:0] max_len;
        logic        enable;
        dest_kind_t  exp_class;
        logic [3:0]  exp_flags;
    } frame_case_t;

    logic             clk;
    logic             reset_crc;
    gmii_beat_t       gmii_in;
    logic [len_w-1:0] cfg_max_len;
    logic             cfg_enable;
    rx_stream_t       rx_out;
    rx_stat_t         rx_stat;
    frame_case_t      cases [n_tests];
    string            names [n_tests] = '{"good_ucast", "bad_fcs", "bcast", "mcast",
                                          "oversize", "framing_err", "disabled", "at_max_len"};
    int               total_errs;

    gmii_rx_top uut (
        .clk         (clk),
        .reset_crc   (reset_crc),
        .gmii_in     (gmii_in),
        .cfg_max_len (cfg_max_len),
        .cfg_enable  (cfg_enable),
        .rx_out      (rx_out),
        .rx_stat     (rx_stat)
    );

    rx_checker chk (
        .clk       (clk),
        .reset_crc (reset_crc),
        .rx_out    (rx_out),
        .rx_stat   (rx_stat)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reflected CRC-32 with the byte folded in before the shifts
    function automatic logic [31:0] crc_add_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'h0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic drive_beat(input logic [7:0] d, input logic dv, input logic er);
        @(posedge clk);
        #drive_delay;
        gmii_in = {d, dv, er};
    endtask

    task automatic send_frame(input int idx);
        frame_case_t c;
        logic [7:0]  bytes [$];
        logic [31:0] fcs;
        rx_stat_t    stat;
        int          pulses;
        c = cases[idx];
        fcs = '1;
        cfg_max_len = c.max_len;
        cfg_enable  = c.enable;
        for (int i = 0; i < 6; i++) begin
            bytes.push_back(c.dest == dest_bcast ? 8'hff :
                            c.dest == dest_mcast ? mcast_mac[47-8*i -: 8] : ucast_mac[47-8*i -: 8]);
        end
        for (int i = 0; i < 6; i++) begin
            bytes.push_back(src_mac[47-8*i -: 8]);
        end
        repeat (c.pay_len) begin
            bytes.push_back(8'($urandom));
        end
        foreach (bytes[i]) begin
            fcs = crc_add_byte(fcs, bytes[i]);
        end
        // sent complemented with the low byte first
        fcs = ~fcs ^ {31'h0, c.bad_fcs};
        stat = '0;
        stat.pkt_len = 16'(bytes.size() + 4);
        // the last FCS byte is still accepted on the closing cycle
        stat.rx_byte = 1'b1;
        stat.ucast   = (c.exp_class == dest_ucast);
        stat.mcast   = (c.exp_class == dest_mcast);
        stat.bcast   = (c.exp_class == dest_bcast);
        stat.bad     = !c.exp_flags[3];
        {stat.good, stat.err_oversize, stat.err_bad_fcs, stat.err_framing} = c.exp_flags;
        // SFD plus every byte after it
        pulses = c.enable ? int'(stat.pkt_len) + 1 : 0;
        chk.start_frame(names[idx], c.enable, pulses, stat, !c.exp_flags[3]);
        foreach (bytes[i]) begin
            chk.push_byte(bytes[i]);
        end
        for (int i = 0; i < 4; i++) begin
            bytes.push_back(fcs[8*i +: 8]);
        end
        repeat (7) begin
            drive_beat(eth_pre, 1'b1, 1'b0);
        end
        drive_beat(eth_sfd, 1'b1, 1'b0);
        foreach (bytes[i]) begin
            drive_beat(bytes[i], 1'b1, i == int'(c.err_at));
        end
        repeat (gap_cycles) begin
            drive_beat(8'h00, 1'b0, 1'b0);
        end
        chk.wait_frame();
    endtask

    initial begin
        void'($urandom(7));
        reset_crc   = 1'b1;
        gmii_in     = '0;
        cfg_max_len = default_max_len;
        cfg_enable  = 1'b0;
        // dest, payload, bad FCS, er index, max len, enable, class, flags
        cases[0] = '{dest_ucast, 16'd46, 1'b0, no_err, 16'd1518, 1'b1, dest_ucast, 4'b1000};
        cases[1] = '{dest_ucast, 16'd50, 1'b1, no_err, 16'd1518, 1'b1, dest_ucast, 4'b0010};
        cases[2] = '{dest_bcast, 16'd46, 1'b0, no_err, 16'd1518, 1'b1, dest_bcast, 4'b1000};
        cases[3] = '{dest_mcast, 16'd46, 1'b0, no_err, 16'd1518, 1'b1, dest_mcast, 4'b1000};
        cases[4] = '{dest_ucast, 16'd100, 1'b0, no_err, 16'd100, 1'b1, dest_ucast, 4'b0100};
        cases[5] = '{dest_ucast, 16'd60, 1'b0, 16'd30, 16'd1518, 1'b1, dest_ucast, 4'b0001};
        cases[6] = '{dest_ucast, 16'd46, 1'b0, no_err, 16'd1518, 1'b0, dest_ucast, 4'b0000};
        // 62 bytes on the wire hit the limit exactly
        cases[7] = '{dest_ucast, 16'd46, 1'b0, no_err, 16'd62, 1'b1, dest_ucast, 4'b1000};
        repeat (3) @(posedge clk);
        #drive_delay;
        reset_crc = 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            send_frame(t);
        end
        total_errs = chk.data_errs + chk.stat_errs + chk.proto_errs + chk.timeout_errs;
        $display("errors: data %0d, stat %0d, protocol %0d, timeout %0d",
                 chk.data_errs, chk.stat_errs, chk.proto_errs, chk.timeout_errs);
        if (total_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
